// File: compile.f
+incdir+hdl
hdl/pkt_pkg.sv
hdl/axis_to_packet_adapter.sv
hdl/packet_skid_buffer.sv
hdl/packet_len_monitor.sv
hdl/axis_packet_rx_top.sv
dv/tb_axis_packet_rx.sv

// File: dv/tb_axis_packet_rx.sv
// ****************************************
// Testbench for the AXI-Stream packet receive path
// Random packets, stalls and a summary reference model
// ****************************************
`default_nettype none

`include "pkt_consts.svh"

module tb_axis_packet_rx;
    timeunit 1ns;
    timeprecision 100ps;

    import pkt_pkg::*;

    localparam int NUM_PKTS = 64;
    localparam int IDX_WID  = $clog2(NUM_PKTS);

    logic                     __packet_if;
    logic                     rst;
    logic                     axis_vld;
    logic                     axis_rdy;
    axis_beat_t               axis_beat;
    logic [`PKT_META_WID-1:0] meta;
    logic                     err;
    logic                     sink_rdy;
    logic                     sum_vld;
    pkt_summary_t             summary;
    logic [`PKT_CNT_WID-1:0]  pkt_count;
    logic                     axis_xfer;

    integer seed       = 32'h4729_4a36;
    integer stall_seed = 32'h4729_4a36;

    // Reference model filled before the first beat is sent
    int                       pkt_len  [NUM_PKTS];
    logic [`PKT_META_WID-1:0] pkt_meta [NUM_PKTS];
    logic                     pkt_err  [NUM_PKTS];
    pkt_summary_t             exp_sum  [NUM_PKTS];

    logic [`PKT_CNT_WID-1:0]  sum_seen;
    logic [IDX_WID-1:0]       sum_idx;
    int                       stall_xfers;
    int                       cycle_cnt;
    int                       cycle_limit = 0;

    axis_packet_rx_top i_axis_packet_rx_top (
        .__packet_if (__packet_if),
        .rst         (rst),
        .axis_vld    (axis_vld),
        .axis_rdy    (axis_rdy),
        .axis_beat   (axis_beat),
        .meta        (meta),
        .err         (err),
        .sink_rdy    (sink_rdy),
        .sum_vld     (sum_vld),
        .summary     (summary),
        .pkt_count   (pkt_count)
    );

    assign axis_xfer = axis_vld && axis_rdy;

    // 8 ns period
    initial begin
        __packet_if = 1'b0;
        forever #4 __packet_if = ~__packet_if;
    end

    task automatic report_error(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // One packet with meta valid on the first beat and err on the last
    task automatic send_packet(input int p);
        int          nbeats;
        int          valid;
        logic [31:0] rnd;
        nbeats = (pkt_len[p] + `PKT_DATA_BYTES - 1) / `PKT_DATA_BYTES;
        for (int b = 0; b < nbeats; b++) begin
            rnd = $random(seed);
            while (rnd[1:0] == 2'b00) begin
                axis_vld = 1'b0;
                @(negedge __packet_if);
                rnd = $random(seed);
            end
            axis_vld        = 1'b1;
            axis_beat.tdata = {$random(seed), $random(seed)};
            axis_beat.tlast = (b == nbeats - 1);
            rnd = $random(seed);
            if (b == nbeats - 1) begin
                valid           = pkt_len[p] - b * `PKT_DATA_BYTES;
                axis_beat.tkeep = `PKT_DATA_BYTES'((1 << valid) - 1);
                err             = pkt_err[p];
            end else begin
                axis_beat.tkeep = '1;
                err             = rnd[8];
            end
            if (b == 0) begin
                meta = pkt_meta[p];
            end else begin
                meta = rnd[`PKT_META_WID-1:0];
            end
            // Ready is a flop and holds its value through the next rising edge
            while (!axis_rdy) begin
                @(negedge __packet_if);
            end
            @(negedge __packet_if);
        end
        axis_vld = 1'b0;
    endtask

    // Quiet start then periodic long stalls mixed with random ones
    initial begin : sink_stalls
        int          cyc;
        logic [31:0] rnd;
        sink_rdy = 1'b1;
        cyc      = 0;
        forever begin
            @(negedge __packet_if);
            cyc++;
            if (cyc < 40) begin
                sink_rdy = 1'b1;
            end else if ((cyc % 64) < 12) begin
                sink_rdy = 1'b0;
            end else begin
                rnd      = $random(stall_seed);
                sink_rdy = (rnd[1:0] != 2'b00);
            end
        end
    end

    always @(posedge __packet_if) begin
        if (rst) begin
            sum_seen    <= '0;
            sum_idx     <= '0;
            stall_xfers <= 0;
        end else begin
            if (sum_vld) begin
                sum_seen <= sum_seen + 1'b1;
                sum_idx  <= sum_idx + 1'b1;
            end
            // Beats taken since the sink went quiet
            if (sink_rdy) begin
                stall_xfers <= 0;
            end else begin
                stall_xfers <= stall_xfers + int'(axis_xfer);
            end
        end
    end

    reset_outputs_clear: assert property (@(posedge __packet_if)
        $past(rst) && !rst |-> !sum_vld && pkt_count == '0 && !axis_rdy)
        else report_error("outputs not clear right after reset");

    rdy_after_reset: assert property (@(posedge __packet_if)
        $past(rst, 3) && !$past(rst, 2) |-> axis_rdy || $past(axis_rdy))
        else report_error("axis_rdy did not rise within 2 cycles of reset");

    summary_matches: assert property (@(posedge __packet_if) disable iff (rst)
        sum_vld |-> summary == exp_sum[sum_idx])
        else report_error($sformatf(
            "packet %0d summary bytes %0d beats %0d meta %0h status %0d, expected %0d %0d %0h %0d",
            sum_idx, summary.byte_len, summary.beat_len, summary.meta, summary.status,
            exp_sum[sum_idx].byte_len, exp_sum[sum_idx].beat_len, exp_sum[sum_idx].meta,
            exp_sum[sum_idx].status));

    no_extra_summary: assert property (@(posedge __packet_if) disable iff (rst)
        sum_vld |-> sum_seen < `PKT_CNT_WID'(NUM_PKTS))
        else report_error("more summaries than packets sent");

    count_tracks_summaries: assert property (@(posedge __packet_if) disable iff (rst)
        pkt_count == sum_seen + `PKT_CNT_WID'(sum_vld))
        else report_error($sformatf("pkt_count %0d with %0d summaries", pkt_count, sum_seen));

    // With the sink open on both edges the tlast beat bypasses the buffer
    tlast_to_sum_latency: assert property (@(posedge __packet_if) disable iff (rst)
        $past(axis_xfer && axis_beat.tlast, 2) && $past(sink_rdy, 2) && $past(sink_rdy)
        |-> sum_vld)
        else report_error("sum_vld missing 2 cycles after tlast with no stall");

    rdy_drops_on_stall: assert property (@(posedge __packet_if) disable iff (rst)
        $past(axis_xfer, 2) && !$past(sink_rdy, 2) && !$past(sink_rdy) |-> !axis_rdy)
        else report_error("axis_rdy still high after the sink stalled");

    stall_within_capacity: assert property (@(posedge __packet_if) disable iff (rst)
        stall_xfers <= `PKT_SKID_DEPTH)
        else report_error($sformatf("%0d beats taken during one stall", stall_xfers));

    initial begin : watchdog
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge __packet_if);
            cycle_cnt++;
        end
        $display("Timeout: not all summaries arrived within %0d cycles", cycle_limit);
        $display("Simulation FAILED");
        $fatal(1, "run stopped on timeout");
    end

    initial begin : stimulus
        int          len;
        int          nbeats;
        int          total_beats;
        logic [31:0] rnd;
        rst       = 1'b1;
        axis_vld  = 1'b0;
        axis_beat = '0;
        meta      = '0;
        err       = 1'b0;

        // Short packets first to cover every last-beat fill and the runt edge
        total_beats = 0;
        for (int p = 0; p < NUM_PKTS; p++) begin
            if (p < `PKT_DATA_BYTES) begin
                len = p + 1;
            end else if (p == `PKT_DATA_BYTES) begin
                len = `PKT_MIN_BYTES - 1;
            end else if (p == `PKT_DATA_BYTES + 1) begin
                len = `PKT_MIN_BYTES;
            end else begin
                rnd = $random(seed);
                len = 1 + int'(rnd[15:0] % 16'd40);
            end
            rnd         = $random(seed);
            nbeats      = (len + `PKT_DATA_BYTES - 1) / `PKT_DATA_BYTES;
            total_beats = total_beats + nbeats;
            pkt_len[p]  = len;
            pkt_meta[p] = rnd[`PKT_META_WID-1:0];
            pkt_err[p]  = (rnd[5:4] == 2'b00);
            exp_sum[p].byte_len = `PKT_LEN_WID'(len);
            exp_sum[p].beat_len = `PKT_LEN_WID'(nbeats);
            exp_sum[p].meta     = rnd[`PKT_META_WID-1:0];
            if (pkt_err[p]) begin
                exp_sum[p].status = PKT_ERR;
            end else if (len < `PKT_MIN_BYTES) begin
                exp_sum[p].status = PKT_RUNT;
            end else begin
                exp_sum[p].status = PKT_OK;
            end
        end
        cycle_limit = 4 * total_beats + 200;

        repeat (3) @(negedge __packet_if);
        rst = 1'b0;

        for (int p = 0; p < NUM_PKTS; p++) begin
            send_packet(p);
        end

        wait (sum_seen == `PKT_CNT_WID'(NUM_PKTS));
        // Idle time to catch a late duplicate
        repeat (20) @(negedge __packet_if);
        if (pkt_count == `PKT_CNT_WID'(NUM_PKTS) && sum_seen == `PKT_CNT_WID'(NUM_PKTS)) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            report_error($sformatf("%0d summaries and pkt_count %0d for %0d packets",
                sum_seen, pkt_count, NUM_PKTS));
        end
    end

endmodule

`default_nettype wire

// File: hdl/axis_packet_rx_top.sv
// ****************************************
// AXI-Stream packet receive top level
// Adapter, skid buffer and length monitor
// ****************************************
`default_nettype none

`include "pkt_consts.svh"

module axis_packet_rx_top (
    input  logic                    __packet_if,
    input  logic                    rst,
    input  logic                    axis_vld,
    output logic                    axis_rdy,
    input  pkt_pkg::axis_beat_t     axis_beat,
    input  logic [`PKT_META_WID-1:0] meta,
    input  logic                    err,
    input  logic                    sink_rdy,
    output logic                    sum_vld,
    output pkt_pkg::pkt_summary_t   summary,
    output logic [`PKT_CNT_WID-1:0] pkt_count
);
    import pkt_pkg::*;

    // Adapter to buffer
    logic         in_vld;
    packet_beat_t in_beat;
    logic         early_rdy;

    // Buffer to monitor
    logic         out_vld;
    packet_beat_t out_beat;
    logic         out_rdy;

    axis_to_packet_adapter i_axis_to_packet_adapter (
        .__packet_if (__packet_if),
        .rst         (rst),
        .axis_vld    (axis_vld),
        .axis_rdy    (axis_rdy),
        .axis_beat   (axis_beat),
        .meta        (meta),
        .err         (err),
        .in_vld      (in_vld),
        .in_beat     (in_beat),
        .early_rdy   (early_rdy)
    );

    packet_skid_buffer i_packet_skid_buffer (
        .__packet_if (__packet_if),
        .rst         (rst),
        .in_vld      (in_vld),
        .in_beat     (in_beat),
        .early_rdy   (early_rdy),
        .out_vld     (out_vld),
        .out_beat    (out_beat),
        .out_rdy     (out_rdy)
    );

    packet_len_monitor i_packet_len_monitor (
        .__packet_if (__packet_if),
        .rst         (rst),
        .out_vld     (out_vld),
        .out_beat    (out_beat),
        .out_rdy     (out_rdy),
        .sink_rdy    (sink_rdy),
        .sum_vld     (sum_vld),
        .summary     (summary),
        .pkt_count   (pkt_count)
    );

endmodule

`default_nettype wire

// File: hdl/axis_to_packet_adapter.sv
// ****************************************
// AXI-Stream to packet beat adapter
// Registers beats, reorders bytes, tkeep to mty
// ****************************************
`default_nettype none

`include "pkt_consts.svh"

module axis_to_packet_adapter (
    input  logic                     __packet_if,
    input  logic                     rst,
    input  logic                     axis_vld,
    output logic                     axis_rdy,
    input  pkt_pkg::axis_beat_t      axis_beat,
    input  logic [`PKT_META_WID-1:0] meta,
    input  logic                     err,
    output logic                     in_vld,
    output pkt_pkg::packet_beat_t    in_beat,
    input  logic                     early_rdy
);
    import pkt_pkg::*;

    logic         axis_xfer;
    packet_beat_t beat_q;

    // Count of cleared tkeep bits, only the top bytes may be empty
    function automatic logic [`PKT_MTY_WID-1:0] tkeep_to_mty(
        input logic [`PKT_DATA_BYTES-1:0] tkeep
    );
        logic [`PKT_MTY_WID-1:0] mty;
        mty = '0;
        for (int i = 0; i < `PKT_DATA_BYTES; i++) begin
            if (!tkeep[i]) begin
                mty = mty + 1'b1;
            end
        end
        return mty;
    endfunction

    // Low tdata byte moves to the leading packet byte
    function automatic logic [0:`PKT_DATA_BYTES-1][7:0] to_packet_order(
        input logic [`PKT_DATA_BYTES*8-1:0] tdata
    );
        logic [0:`PKT_DATA_BYTES-1][7:0] data;
        for (int i = 0; i < `PKT_DATA_BYTES; i++) begin
            data[i] = tdata[i*8 +: 8];
        end
        return data;
    endfunction

    // Ready comes from the buffer, which already counts the beat held here
    assign axis_rdy  = early_rdy;
    assign axis_xfer = axis_vld && axis_rdy;

    always_ff @(posedge __packet_if) begin
        if (rst) begin
            in_vld <= 1'b0;
        end else begin
            in_vld <= axis_xfer;
        end
    end

    always_ff @(posedge __packet_if) begin
        if (axis_xfer) begin
            beat_q.data <= to_packet_order(axis_beat.tdata);
            beat_q.eop  <= axis_beat.tlast;
            // Empty bytes only on the last beat
            if (axis_beat.tlast) begin
                beat_q.mty <= tkeep_to_mty(axis_beat.tkeep);
            end else begin
                beat_q.mty <= '0;
            end
            beat_q.err  <= err;
            beat_q.meta <= meta;
        end
    end

    assign in_beat = beat_q;

endmodule

`default_nettype wire

// File: hdl/packet_len_monitor.sv
// ****************************************
// Packet length monitor
// Byte and beat count, one summary per packet
// ****************************************
`default_nettype none

`include "pkt_consts.svh"

module packet_len_monitor (
    input  logic                    __packet_if,
    input  logic                    rst,
    input  logic                    out_vld,
    input  pkt_pkg::packet_beat_t   out_beat,
    output logic                    out_rdy,
    input  logic                    sink_rdy,
    output logic                    sum_vld,
    output pkt_pkg::pkt_summary_t   summary,
    output logic [`PKT_CNT_WID-1:0] pkt_count
);
    import pkt_pkg::*;

    mon_state_e               state;
    mon_state_e               state_next;
    logic                     beat_xfer;
    logic                     eop_xfer;
    logic                     first_beat;
    logic [`PKT_LEN_WID-1:0]  beat_bytes;
    logic [`PKT_LEN_WID-1:0]  byte_acc;
    logic [`PKT_LEN_WID-1:0]  beat_acc;
    logic [`PKT_LEN_WID-1:0]  byte_total;
    logic [`PKT_LEN_WID-1:0]  beat_total;
    logic [`PKT_META_WID-1:0] meta_q;
    logic [`PKT_META_WID-1:0] meta_pkt;
    pkt_status_e              status;

    // Sink stall passes straight back to the buffer
    assign out_rdy = sink_rdy;

    assign beat_xfer  = out_vld && out_rdy;
    assign eop_xfer   = beat_xfer && out_beat.eop;
    assign first_beat = (state == MON_IDLE);

    // Full beat, less the empty bytes on eop
    always_comb begin
        beat_bytes = `PKT_LEN_WID'(`PKT_DATA_BYTES);
        if (out_beat.eop) begin
            beat_bytes = `PKT_LEN_WID'(`PKT_DATA_BYTES) - `PKT_LEN_WID'(out_beat.mty);
        end
    end

    // Totals including the beat now on the bus
    assign byte_total = first_beat ? beat_bytes : byte_acc + beat_bytes;
    assign beat_total = first_beat ? `PKT_LEN_WID'(1) : beat_acc + 1'b1;
    assign meta_pkt   = first_beat ? out_beat.meta : meta_q;

    // Error wins over runt
    always_comb begin
        if (out_beat.err) begin
            status = PKT_ERR;
        end else if (byte_total < `PKT_LEN_WID'(`PKT_MIN_BYTES)) begin
            status = PKT_RUNT;
        end else begin
            status = PKT_OK;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            MON_IDLE: begin
                // Single-beat packets never leave idle
                if (beat_xfer && !out_beat.eop) begin
                    state_next = MON_IN_PKT;
                end
            end
            MON_IN_PKT: begin
                if (eop_xfer) begin
                    state_next = MON_IDLE;
                end
            end
            default: begin
                state_next = MON_IDLE;
            end
        endcase
    end

    always_ff @(posedge __packet_if) begin
        if (rst) begin
            state     <= MON_IDLE;
            sum_vld   <= 1'b0;
            pkt_count <= '0;
        end else begin
            state   <= state_next;
            sum_vld <= eop_xfer;
            if (eop_xfer) begin
                pkt_count <= pkt_count + 1'b1;
            end
        end
    end

    always_ff @(posedge __packet_if) begin
        if (beat_xfer) begin
            byte_acc <= byte_total;
            beat_acc <= beat_total;
            meta_q   <= meta_pkt;
        end
        if (eop_xfer) begin
            summary.byte_len <= byte_total;
            summary.beat_len <= beat_total;
            summary.meta     <= meta_pkt;
            summary.status   <= status;
        end
    end

endmodule

`default_nettype wire

// File: hdl/packet_skid_buffer.sv
// ****************************************
// Packet skid buffer
// Small FIFO with bypass and registered ready
// ****************************************
`default_nettype none

`include "pkt_consts.svh"

module packet_skid_buffer (
    input  logic                  __packet_if,
    input  logic                  rst,
    input  logic                  in_vld,
    input  pkt_pkg::packet_beat_t in_beat,
    output logic                  early_rdy,
    output logic                  out_vld,
    output pkt_pkg::packet_beat_t out_beat,
    input  logic                  out_rdy
);
    import pkt_pkg::*;

    localparam int DEPTH   = `PKT_SKID_DEPTH;
    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    packet_beat_t       mem [DEPTH];
    logic [PTR_WID-1:0] rd_ptr;
    logic [PTR_WID-1:0] wr_ptr;
    logic [CNT_WID-1:0] count;
    logic [CNT_WID-1:0] count_next;
    logic               empty;
    logic               bypass;
    logic               wr_en;
    logic               rd_en;

    function automatic logic [PTR_WID-1:0] ptr_inc(input logic [PTR_WID-1:0] ptr);
        if (ptr == PTR_WID'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);

    // Empty buffer and a taker ready, so the beat skips the storage
    assign bypass = empty && in_vld && out_rdy;
    assign wr_en  = in_vld && !bypass;
    assign rd_en  = !empty && out_rdy;

    assign out_vld  = !empty || in_vld;
    assign out_beat = empty ? in_beat : mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (wr_en && !rd_en) begin
            count_next = count + 1'b1;
        end else if (rd_en && !wr_en) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge __packet_if) begin
        if (rst) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            count     <= '0;
            early_rdy <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count_next;
            // One entry stays free for the beat in the adapter register,
            // which lands a cycle after ready is sampled
            early_rdy <= (count_next < CNT_WID'(DEPTH - 1));
        end
    end

    always_ff @(posedge __packet_if) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pkt_consts.svh
// ****************************************
// Packet receive path constants
// Beat geometry, buffer depth, counter sizes
// ****************************************
`ifndef PKT_CONSTS_SVH
`define PKT_CONSTS_SVH

// Beat geometry
`define PKT_DATA_BYTES 8
`define PKT_MTY_WID    3
`define PKT_META_WID   4

// Packets shorter than this are runts
`define PKT_MIN_BYTES  12

// Entries behind the adapter register
`define PKT_SKID_DEPTH 2

// Summary counters
`define PKT_LEN_WID    16
`define PKT_CNT_WID    16

`endif

// File: hdl/pkt_pkg.sv
// ****************************************
// Packet receive path types
// Beat formats, summary record, enums
// ****************************************
`default_nettype none

`include "pkt_consts.svh"

package pkt_pkg;

    // AXI-Stream beat, tdata byte 0 in the low bits
    typedef struct packed {
        logic [`PKT_DATA_BYTES*8-1:0] tdata;
        logic [`PKT_DATA_BYTES-1:0]   tkeep;
        logic                         tlast;
    } axis_beat_t;

    // Generic packet beat, data[0] is the first byte on the wire
    typedef struct packed {
        logic [0:`PKT_DATA_BYTES-1][7:0] data;
        logic                            eop;
        logic [`PKT_MTY_WID-1:0]         mty;
        logic                            err;
        logic [`PKT_META_WID-1:0]        meta;
    } packet_beat_t;

    typedef enum logic [1:0] {
        PKT_OK   = 2'd0,
        PKT_RUNT = 2'd1,
        PKT_ERR  = 2'd2
    } pkt_status_e;

    typedef enum logic {
        MON_IDLE   = 1'b0,
        MON_IN_PKT = 1'b1
    } mon_state_e;

    // One record per packet
    typedef struct packed {
        logic [`PKT_LEN_WID-1:0]  byte_len;
        logic [`PKT_LEN_WID-1:0]  beat_len;
        logic [`PKT_META_WID-1:0] meta;
        pkt_status_e              status;
    } pkt_summary_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the packet receive testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f compile.f --top-module tb_axis_packet_rx -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_axis_packet_rx)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
